// ==== source/axil_mem_pkg.sv ====
package axil_mem_pkg;

  // Physical address, shared by the AXI side and the message headers
  localparam int addr_width_c = 32;

  // Requester identity fields
  localparam int lce_id_width_c = 4;
  localparam int did_width_c    = 3;

  typedef enum logic [3:0] {
    e_mem_uc_rd = 4'b0000
    , e_mem_uc_wr = 4'b0001
  } mem_msg_e;

  // Log2 of the number of bytes in the access
  typedef enum logic [2:0] {
    e_size_1   = 3'b000
    , e_size_2 = 3'b001
    , e_size_4 = 3'b010
    , e_size_8 = 3'b011
  } msg_size_e;

  typedef struct packed {
    logic [lce_id_width_c-1:0] lce_id;
    logic [did_width_c-1:0]    did;
  } mem_payload_s;

  typedef struct packed {
    mem_msg_e                msg_type;
    msg_size_e               size;
    logic [addr_width_c-1:0] addr;
    mem_payload_s            payload;
  } mem_fwd_header_s;

  // Target echoes the forward header here
  typedef struct packed {
    mem_msg_e                msg_type;
    msg_size_e               size;
    logic [addr_width_c-1:0] addr;
    mem_payload_s            payload;
  } mem_rev_header_s;

  // One serialized AXI access, data and strobe travel beside it
  typedef struct packed {
    logic                    w;
    logic [addr_width_c-1:0] addr;
  } axil_req_s;

endpackage

// ==== source/axil_fifo_client.sv ====
module axil_fifo_client
  #(parameter int axil_data_width_p = 32
    , localparam int mask_width_lp = axil_data_width_p / 8
    )
  (input                                          clk_i
   , input                                        arst_n_i

   // AXI4-Lite slave
   , input [axil_mem_pkg::addr_width_c-1:0]       s_axil_awaddr_i
   , input [2:0]                                  s_axil_awprot_i
   , input                                        s_axil_awvalid_i
   , output logic                                 s_axil_awready_o

   , input [axil_data_width_p-1:0]                s_axil_wdata_i
   , input [mask_width_lp-1:0]                    s_axil_wstrb_i
   , input                                        s_axil_wvalid_i
   , output logic                                 s_axil_wready_o

   , output logic [1:0]                           s_axil_bresp_o
   , output logic                                 s_axil_bvalid_o
   , input                                        s_axil_bready_i

   , input [axil_mem_pkg::addr_width_c-1:0]       s_axil_araddr_i
   , input [2:0]                                  s_axil_arprot_i
   , input                                        s_axil_arvalid_i
   , output logic                                 s_axil_arready_o

   , output logic [axil_data_width_p-1:0]         s_axil_rdata_o
   , output logic [1:0]                           s_axil_rresp_o
   , output logic                                 s_axil_rvalid_o
   , input                                        s_axil_rready_i

   // Request stream to the bridge
   , output axil_mem_pkg::axil_req_s              req_o
   , output logic [axil_data_width_p-1:0]         req_data_o
   , output logic [mask_width_lp-1:0]             req_wmask_o
   , output logic                                 req_v_o
   , input                                        req_ready_and_i

   // Read data coming back
   , input [axil_data_width_p-1:0]                resp_data_i
   , input                                        resp_v_i
   , output logic                                 resp_ready_and_o
   );

  typedef enum logic [1:0] {
    st_idle
    , st_request
    , st_wait
    , st_respond
  } state_e;

  state_e state_q, state_n;
  logic aw_got_q, w_got_q;
  logic aw_hs, w_hs, ar_hs, aw_done, w_done;
  axil_mem_pkg::axil_req_s req_q;
  logic [axil_data_width_p-1:0] data_q, rdata_q;
  logic [mask_width_lp-1:0] wmask_q;

  assign s_axil_awready_o = (state_q == st_idle) & ~aw_got_q;
  assign s_axil_wready_o  = (state_q == st_idle) & ~w_got_q;
  // Writes win, so a read waits for any write activity to clear
  assign s_axil_arready_o = (state_q == st_idle) & ~aw_got_q & ~w_got_q
                            & ~s_axil_awvalid_i & ~s_axil_wvalid_i;

  assign aw_hs   = s_axil_awvalid_i & s_axil_awready_o;
  assign w_hs    = s_axil_wvalid_i & s_axil_wready_o;
  assign ar_hs   = s_axil_arvalid_i & s_axil_arready_o;
  assign aw_done = aw_got_q | aw_hs;
  assign w_done  = w_got_q | w_hs;

  always_comb begin
    state_n = state_q;
    case (state_q)
      st_idle:    if (ar_hs || (aw_done && w_done)) state_n = st_request;
      st_request: if (req_ready_and_i) state_n = st_wait;
      st_wait:    if (resp_v_i) state_n = st_respond;
      st_respond: begin
        if (req_q.w ? s_axil_bready_i : s_axil_rready_i) state_n = st_idle;
      end
      default:    state_n = st_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= st_idle;
      aw_got_q <= 1'b0;
      w_got_q  <= 1'b0;
    end else begin
      state_q <= state_n;
      // Both halves of the write are consumed together
      if (state_q == st_idle && aw_done && w_done) begin
        aw_got_q <= 1'b0;
        w_got_q  <= 1'b0;
      end else begin
        aw_got_q <= aw_done;
        w_got_q  <= w_done;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      req_q.w    <= 1'b1;
      req_q.addr <= s_axil_awaddr_i;
    end else if (ar_hs) begin
      req_q.w    <= 1'b0;
      req_q.addr <= s_axil_araddr_i;
    end
    if (w_hs) begin
      data_q  <= s_axil_wdata_i;
      wmask_q <= s_axil_wstrb_i;
    end
    if (resp_v_i && resp_ready_and_o) rdata_q <= resp_data_i;
  end

  assign req_o            = req_q;
  assign req_data_o       = data_q;
  assign req_wmask_o      = wmask_q;
  assign req_v_o          = (state_q == st_request);
  assign resp_ready_and_o = (state_q == st_wait);

  assign s_axil_bresp_o  = 2'b00;
  assign s_axil_bvalid_o = (state_q == st_respond) & req_q.w;
  assign s_axil_rresp_o  = 2'b00;
  assign s_axil_rvalid_o = (state_q == st_respond) & ~req_q.w;
  assign s_axil_rdata_o  = rdata_q;

  // Master must hold the address while it waits for ready
  awaddr_stable_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    s_axil_awvalid_i && !s_axil_awready_o |=> $stable(s_axil_awaddr_i));

  araddr_stable_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    s_axil_arvalid_i && !s_axil_arready_o |=> $stable(s_axil_araddr_i));

  // Memory side only answers a request we sent
  no_resp_idle_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    state_q == st_idle |-> !resp_v_i);

endmodule

// ==== source/axil_mem_client.sv ====
module axil_mem_client
  #(parameter int axil_data_width_p = 32
    , localparam int mask_width_lp = axil_data_width_p / 8
    , localparam int lg_mask_width_lp = $clog2(mask_width_lp)
    )
  (input [axil_mem_pkg::lce_id_width_c-1:0]       lce_id_i
   , input [axil_mem_pkg::did_width_c-1:0]        did_i

   // Request stream from the front end
   , input axil_mem_pkg::axil_req_s               req_i
   , input [axil_data_width_p-1:0]                req_data_i
   , input [mask_width_lp-1:0]                    req_wmask_i
   , input                                        req_v_i
   , output logic                                 req_ready_and_o

   , output logic [axil_data_width_p-1:0]         resp_data_o
   , output logic                                 resp_v_o
   , input                                        resp_ready_and_i

   // Memory forward stream
   , output axil_mem_pkg::mem_fwd_header_s        mem_fwd_header_o
   , output logic [axil_data_width_p-1:0]         mem_fwd_data_o
   , output logic                                 mem_fwd_v_o
   , input                                        mem_fwd_ready_and_i
   , output logic                                 mem_fwd_last_o

   // Memory reverse stream
   , input axil_mem_pkg::mem_rev_header_s         mem_rev_header_i
   , input [axil_data_width_p-1:0]                mem_rev_data_i
   , input                                        mem_rev_v_i
   , output logic                                 mem_rev_ready_and_o
   , input                                        mem_rev_last_i
   );

  axil_mem_pkg::msg_size_e size_lo;
  logic [lg_mask_width_lp-1:0] offset_lo;

  // Strobe to size and lowest lane
  // Masks that match no pattern go full width
  always_comb begin
    size_lo   = axil_mem_pkg::msg_size_e'(lg_mask_width_lp);
    offset_lo = '0;
    if (req_i.w) begin
      for (int i = 0; i < mask_width_lp; i++) begin
        if (req_wmask_i == (mask_width_lp'(1) << i)) begin
          size_lo   = axil_mem_pkg::e_size_1;
          offset_lo = lg_mask_width_lp'(i);
        end
      end
      for (int i = 0; i < mask_width_lp; i += 2) begin
        if (req_wmask_i == (mask_width_lp'(2'b11) << i)) begin
          size_lo   = axil_mem_pkg::e_size_2;
          offset_lo = lg_mask_width_lp'(i);
        end
      end
      for (int i = 0; i < mask_width_lp; i += 4) begin
        if (req_wmask_i == (mask_width_lp'(4'hF) << i)) begin
          size_lo   = axil_mem_pkg::e_size_4;
          offset_lo = lg_mask_width_lp'(i);
        end
      end
    end
  end

  always_comb begin
    mem_fwd_header_o                = '0;
    mem_fwd_header_o.payload.lce_id = lce_id_i;
    mem_fwd_header_o.payload.did    = did_i;
    mem_fwd_header_o.msg_type       = req_i.w ? axil_mem_pkg::e_mem_uc_wr
                                              : axil_mem_pkg::e_mem_uc_rd;
    mem_fwd_header_o.size           = size_lo;
    mem_fwd_header_o.addr           = {req_i.addr[axil_mem_pkg::addr_width_c-1:lg_mask_width_lp],
                                       offset_lo};
  end

  assign mem_fwd_data_o  = req_data_i;
  assign mem_fwd_v_o     = req_v_i;
  // Single-beat messages
  assign mem_fwd_last_o  = mem_fwd_v_o;
  assign req_ready_and_o = mem_fwd_ready_and_i;

  assign resp_data_o         = mem_rev_data_i;
  assign resp_v_o            = mem_rev_v_i;
  assign mem_rev_ready_and_o = resp_ready_and_i;

endmodule

// ==== source/uc_mem_target.sv ====
module uc_mem_target
  #(parameter int axil_data_width_p = 32
    , parameter int mem_words_p = 256
    , localparam int mask_width_lp = axil_data_width_p / 8
    , localparam int lg_mask_width_lp = $clog2(mask_width_lp)
    , localparam int idx_width_lp = $clog2(mem_words_p)
    )
  (input                                          clk_i
   , input                                        arst_n_i

   , input axil_mem_pkg::mem_fwd_header_s         mem_fwd_header_i
   , input [axil_data_width_p-1:0]                mem_fwd_data_i
   , input                                        mem_fwd_v_i
   , output logic                                 mem_fwd_ready_and_o
   , input                                        mem_fwd_last_i

   , output axil_mem_pkg::mem_rev_header_s        mem_rev_header_o
   , output logic [axil_data_width_p-1:0]         mem_rev_data_o
   , output logic                                 mem_rev_v_o
   , input                                        mem_rev_ready_and_i
   , output logic                                 mem_rev_last_o
   );

  logic [axil_data_width_p-1:0] mem_q [mem_words_p];
  logic [axil_mem_pkg::addr_width_c-1:0] word_addr;
  logic [idx_width_lp-1:0] idx;
  logic [lg_mask_width_lp-1:0] offset;
  logic [mask_width_lp-1:0] byte_en;
  logic fwd_xfer, is_wr, rev_v_q;
  axil_mem_pkg::mem_rev_header_s rev_header_q;
  logic [axil_data_width_p-1:0] rev_data_q;

  assign fwd_xfer = mem_fwd_v_i & mem_fwd_ready_and_o;
  assign is_wr    = (mem_fwd_header_i.msg_type == axil_mem_pkg::e_mem_uc_wr);

  // Word index wraps at the array depth
  assign word_addr = (mem_fwd_header_i.addr >> lg_mask_width_lp) % mem_words_p;
  assign idx       = word_addr[idx_width_lp-1:0];
  assign offset    = mem_fwd_header_i.addr[lg_mask_width_lp-1:0];

  // Lanes offset .. offset + 2^size - 1
  always_comb begin
    byte_en = '0;
    for (int b = 0; b < mask_width_lp; b++) begin
      if (b >= int'(offset) && b < int'(offset) + (1 << mem_fwd_header_i.size)) begin
        byte_en[b] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < mem_words_p; i++) begin
        mem_q[i] <= '0;
      end
    end else if (fwd_xfer && is_wr) begin
      for (int b = 0; b < mask_width_lp; b++) begin
        if (byte_en[b]) mem_q[idx][8*b +: 8] <= mem_fwd_data_i[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rev_v_q <= 1'b0;
    end else if (fwd_xfer) begin
      rev_v_q <= 1'b1;
    end else if (mem_rev_ready_and_i) begin
      rev_v_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fwd_xfer) begin
      rev_header_q <= mem_fwd_header_i;
      rev_data_q   <= is_wr ? '0 : mem_q[idx];
    end
  end

  // Holds off new work until the reply leaves
  assign mem_fwd_ready_and_o = ~rev_v_q;
  assign mem_rev_header_o    = rev_header_q;
  assign mem_rev_data_o      = rev_data_q;
  assign mem_rev_v_o         = rev_v_q;
  assign mem_rev_last_o      = rev_v_q;

  size_fits_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_fwd_v_i |-> int'(mem_fwd_header_i.size) <= lg_mask_width_lp);

endmodule

// ==== source/axil_mem_top.sv ====
module axil_mem_top
  #(parameter int axil_data_width_p = 32
    , localparam int mask_width_lp = axil_data_width_p / 8
    )
  (input                                          clk_i
   , input                                        arst_n_i

   , input [axil_mem_pkg::lce_id_width_c-1:0]     lce_id_i
   , input [axil_mem_pkg::did_width_c-1:0]        did_i

   , input [axil_mem_pkg::addr_width_c-1:0]       s_axil_awaddr_i
   , input [2:0]                                  s_axil_awprot_i
   , input                                        s_axil_awvalid_i
   , output logic                                 s_axil_awready_o

   , input [axil_data_width_p-1:0]                s_axil_wdata_i
   , input [mask_width_lp-1:0]                    s_axil_wstrb_i
   , input                                        s_axil_wvalid_i
   , output logic                                 s_axil_wready_o

   , output logic [1:0]                           s_axil_bresp_o
   , output logic                                 s_axil_bvalid_o
   , input                                        s_axil_bready_i

   , input [axil_mem_pkg::addr_width_c-1:0]       s_axil_araddr_i
   , input [2:0]                                  s_axil_arprot_i
   , input                                        s_axil_arvalid_i
   , output logic                                 s_axil_arready_o

   , output logic [axil_data_width_p-1:0]         s_axil_rdata_o
   , output logic [1:0]                           s_axil_rresp_o
   , output logic                                 s_axil_rvalid_o
   , input                                        s_axil_rready_i
   );

  axil_mem_pkg::axil_req_s req;
  logic [axil_data_width_p-1:0] req_data, resp_data;
  logic [mask_width_lp-1:0] req_wmask;
  logic req_v, req_ready_and, resp_v, resp_ready_and;

  axil_mem_pkg::mem_fwd_header_s mem_fwd_header;
  axil_mem_pkg::mem_rev_header_s mem_rev_header;
  logic [axil_data_width_p-1:0] mem_fwd_data, mem_rev_data;
  logic mem_fwd_v, mem_fwd_ready_and, mem_fwd_last;
  logic mem_rev_v, mem_rev_ready_and, mem_rev_last;

  axil_fifo_client
   #(.axil_data_width_p(axil_data_width_p))
   fifo_client
    (.req_o(req)
     ,.req_data_o(req_data)
     ,.req_wmask_o(req_wmask)
     ,.req_v_o(req_v)
     ,.req_ready_and_i(req_ready_and)
     ,.resp_data_i(resp_data)
     ,.resp_v_i(resp_v)
     ,.resp_ready_and_o(resp_ready_and)
     ,.*
     );

  axil_mem_client
   #(.axil_data_width_p(axil_data_width_p))
   mem_client
    (.lce_id_i(lce_id_i)
     ,.did_i(did_i)
     ,.req_i(req)
     ,.req_data_i(req_data)
     ,.req_wmask_i(req_wmask)
     ,.req_v_i(req_v)
     ,.req_ready_and_o(req_ready_and)
     ,.resp_data_o(resp_data)
     ,.resp_v_o(resp_v)
     ,.resp_ready_and_i(resp_ready_and)
     ,.mem_fwd_header_o(mem_fwd_header)
     ,.mem_fwd_data_o(mem_fwd_data)
     ,.mem_fwd_v_o(mem_fwd_v)
     ,.mem_fwd_ready_and_i(mem_fwd_ready_and)
     ,.mem_fwd_last_o(mem_fwd_last)
     ,.mem_rev_header_i(mem_rev_header)
     ,.mem_rev_data_i(mem_rev_data)
     ,.mem_rev_v_i(mem_rev_v)
     ,.mem_rev_ready_and_o(mem_rev_ready_and)
     ,.mem_rev_last_i(mem_rev_last)
     );

  uc_mem_target
   #(.axil_data_width_p(axil_data_width_p))
   mem_target
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.mem_fwd_header_i(mem_fwd_header)
     ,.mem_fwd_data_i(mem_fwd_data)
     ,.mem_fwd_v_i(mem_fwd_v)
     ,.mem_fwd_ready_and_o(mem_fwd_ready_and)
     ,.mem_fwd_last_i(mem_fwd_last)
     ,.mem_rev_header_o(mem_rev_header)
     ,.mem_rev_data_o(mem_rev_data)
     ,.mem_rev_v_o(mem_rev_v)
     ,.mem_rev_ready_and_i(mem_rev_ready_and)
     ,.mem_rev_last_o(mem_rev_last)
     );

endmodule

// ==== tests/axil_mem_tb.sv ====
module axil_mem_tb;

  localparam int data_width_c = 32;
  localparam int mask_width_c = data_width_c / 8;
  localparam int mem_words_c  = 256;
  localparam int timeout_c    = 100;

  logic clk;
  logic arst_n;
  logic [axil_mem_pkg::lce_id_width_c-1:0] lce_id;
  logic [axil_mem_pkg::did_width_c-1:0] did;
  logic [axil_mem_pkg::addr_width_c-1:0] awaddr, araddr;
  logic [data_width_c-1:0] wdata, rdata;
  logic [mask_width_c-1:0] wstrb;
  logic [1:0] bresp, rresp;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic [31:0] rng_state;
  logic [data_width_c-1:0] shadow [mem_words_c];
  int checks;

  axil_mem_top #(.axil_data_width_p(data_width_c)) dut0
    (.clk_i(clk)
     ,.arst_n_i(arst_n)
     ,.lce_id_i(lce_id)
     ,.did_i(did)
     ,.s_axil_awaddr_i(awaddr)
     ,.s_axil_awprot_i(3'b000)
     ,.s_axil_awvalid_i(awvalid)
     ,.s_axil_awready_o(awready)
     ,.s_axil_wdata_i(wdata)
     ,.s_axil_wstrb_i(wstrb)
     ,.s_axil_wvalid_i(wvalid)
     ,.s_axil_wready_o(wready)
     ,.s_axil_bresp_o(bresp)
     ,.s_axil_bvalid_o(bvalid)
     ,.s_axil_bready_i(bready)
     ,.s_axil_araddr_i(araddr)
     ,.s_axil_arprot_i(3'b000)
     ,.s_axil_arvalid_i(arvalid)
     ,.s_axil_arready_o(arready)
     ,.s_axil_rdata_o(rdata)
     ,.s_axil_rresp_o(rresp)
     ,.s_axil_rvalid_o(rvalid)
     ,.s_axil_rready_i(rready)
     );

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Aligned lanes, pairs and quads write only their own lanes
  // Every other strobe writes the whole word
  function automatic logic [mask_width_c-1:0] lanes_written(
    input logic [mask_width_c-1:0] strb);
    case (strb)
      4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hc, 4'hf: return strb;
      default: return 4'hf;
    endcase
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_rdata(input logic [data_width_c-1:0] exp,
                             input logic [data_width_c-1:0] act);
    checks++;
    if (act !== exp) begin
      fail_run($sformatf("mismatch at %0t: s_axil_rdata_o expected %h actual %h",
                         $time, exp, act));
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
    checks++;
    if (act !== exp) begin
      fail_run($sformatf("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act));
    end
  endtask

  // Channel drivers start one unit after a rising edge
  // Ready is sampled at the falling edge where it is settled
  task automatic send_aw(input logic [31:0] addr);
    int n;
    n       = 0;
    awaddr  = addr;
    awvalid = 1'b1;
    @(negedge clk);
    while (!awready) begin
      n++;
      if (n >= timeout_c) fail_run("timed out waiting for the AW handshake");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    awvalid = 1'b0;
  endtask

  task automatic send_w(input logic [31:0] data, input logic [mask_width_c-1:0] strb);
    int n;
    n      = 0;
    wdata  = data;
    wstrb  = strb;
    wvalid = 1'b1;
    @(negedge clk);
    while (!wready) begin
      n++;
      if (n >= timeout_c) fail_run("timed out waiting for the W handshake");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    wvalid = 1'b0;
  endtask

  task automatic send_ar(input logic [31:0] addr);
    int n;
    n       = 0;
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready) begin
      n++;
      if (n >= timeout_c) fail_run("timed out waiting for the AR handshake");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    arvalid = 1'b0;
  endtask

  // Bready drops about one cycle in four
  task automatic wait_b();
    int n;
    logic done;
    n    = 0;
    done = 1'b0;
    while (!done) begin
      rng_state = xorshift32(rng_state);
      bready    = |rng_state[1:0];
      @(negedge clk);
      if (bvalid && bready) begin
        check_resp("s_axil_bresp_o", 2'b00, bresp);
        done = 1'b1;
      end else begin
        n++;
        if (n >= timeout_c) fail_run("timed out waiting for the B handshake");
      end
      @(posedge clk);
      #1;
    end
    bready = 1'b0;
  endtask

  task automatic wait_r(input logic [data_width_c-1:0] exp);
    int n;
    logic done;
    n    = 0;
    done = 1'b0;
    while (!done) begin
      rng_state = xorshift32(rng_state);
      rready    = |rng_state[1:0];
      @(negedge clk);
      if (rvalid && rready) begin
        check_rdata(exp, rdata);
        check_resp("s_axil_rresp_o", 2'b00, rresp);
        done = 1'b1;
      end else begin
        n++;
        if (n >= timeout_c) fail_run("timed out waiting for the R handshake");
      end
      @(posedge clk);
      #1;
    end
    rready = 1'b0;
  endtask

  // AW first, W first, or both together
  task automatic do_write(input logic [31:0] addr, input logic [31:0] data,
                          input logic [mask_width_c-1:0] strb);
    rng_state = xorshift32(rng_state);
    case (rng_state % 32'd3)
      32'd0: begin
        send_aw(addr);
        send_w(data, strb);
      end
      32'd1: begin
        send_w(data, strb);
        send_aw(addr);
      end
      default: begin
        fork
          send_aw(addr);
          send_w(data, strb);
        join
      end
    endcase
    wait_b();
  endtask

  task automatic do_read(input logic [31:0] addr, input logic [data_width_c-1:0] exp);
    send_ar(addr);
    wait_r(exp);
  endtask

  // Each write is read back against a reference copy of the memory
  task automatic write_and_check(input logic [31:0] addr, input logic [31:0] data,
                                 input logic [mask_width_c-1:0] strb);
    logic [mask_width_c-1:0] lanes;
    int idx;
    lanes = lanes_written(strb);
    idx   = int'((addr >> 2) % mem_words_c);
    for (int b = 0; b < mask_width_c; b++) begin
      if (lanes[b]) shadow[idx][8*b +: 8] = data[8*b +: 8];
    end
    do_write(addr, data, strb);
    do_read(addr, shadow[idx]);
  endtask

  initial begin
    int fd;
    int code;
    logic [7:0] op;
    logic [31:0] addr, data, exp;
    logic [mask_width_c-1:0] strb;
    logic [8*256-1:0] rest;
    clk       = 1'b0;
    arst_n    = 1'b0;
    lce_id    = 4'h3;
    did       = 3'h1;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wstrb     = '0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    rng_state = 32'ha635a1fb;
    checks    = 0;
    for (int i = 0; i < mem_words_c; i++) begin
      shadow[i] = '0;
    end
    repeat (4) @(posedge clk);
    #1;
    arst_n = 1'b1;
    @(posedge clk);
    #1;
    fd = $fopen("tests/axil_mem_trace.txt", "r");
    if (fd == 0) fail_run("could not open tests/axil_mem_trace.txt");
    code = $fscanf(fd, " %s", op);
    while (code == 1) begin
      if (op == "#") begin
        code = $fgets(rest, fd);
      end else begin
        code = $fscanf(fd, " %h %h %h %h", addr, data, strb, exp);
        if (code != 4) fail_run("trace line has too few fields");
        if (op == "W") write_and_check(addr, data, strb);
        else if (op == "R") do_read(addr, exp);
        else fail_run("trace line has an unknown operation");
      end
      code = $fscanf(fd, " %s", op);
    end
    $fclose(fd);
    if (checks > 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      fail_run("trace held no transactions");
    end
  end

endmodule

// ==== tests/axil_mem_trace.txt ====
# op addr data strb expect, all hex, expect is ignored on W lines
# Memory is 256 words of 4 bytes, so word addresses alias every 0x400
W 00000000 11223344 f 00000000
R 00000000 00000000 0 11223344
W 00000004 deadbeef f 00000000
R 00000004 00000000 0 deadbeef
R 00000010 00000000 0 00000000
W 00000008 a5a5a5a5 f 00000000
W 00000008 000000cc 1 00000000
W 00000009 0000dd00 2 00000000
W 0000000a 00ee0000 4 00000000
W 0000000b ff000000 8 00000000
R 00000008 00000000 0 ffeeddcc
W 0000000c 12345678 f 00000000
W 0000000c 0000abcd 3 00000000
W 0000000e 9876ffff c 00000000
R 0000000c 00000000 0 9876abcd
W 00000010 cafef00d 5 00000000
R 00000010 00000000 0 cafef00d
W 00000014 0badc0de 0 00000000
R 00000014 00000000 0 0badc0de
R 00000018 00000000 0 00000000
W 00000018 11112222 6 00000000
R 00000018 00000000 0 11112222
W 00000400 5555aaaa f 00000000
R 00000000 00000000 0 5555aaaa
R 00000404 00000000 0 deadbeef
W 000003fc 0f0f0f0f f 00000000
R 000007fc 00000000 0 0f0f0f0f
R 000003f8 00000000 0 00000000

// ==== list.f ====
source/axil_mem_pkg.sv
source/axil_fifo_client.sv
source/axil_mem_client.sv
source/uc_mem_target.sv
source/axil_mem_top.sv
tests/axil_mem_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= axil_mem_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert -j 0

SRCS  := $(filter-out +%,$(shell cat $(FILELIST)))
BIN   := $(BUILD_DIR)/V$(TOP)
TRACE := tests/axil_mem_trace.txt

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN) $(TRACE)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf $(BUILD_DIR)
